// File: build.f
cpuPkg.sv
datapathCtrlIf.sv
controller.sv
programCounter.sv
instructionDecoder.sv
registerFile.sv
datapath.sv
unifiedMemory.sv
cpuTop.sv
cpuTb.sv

// File: cpuTb.sv
module cpuTb;

	timeunit 1ns;
	timeprecision 100ps;

	// --------------------------------------------------
	// constants
	// --------------------------------------------------

	localparam int addrWidth = 8;
	// pc steps before the first fetch, so programs start at word 1
	localparam int progBase = 1;

	// instruction encodings
	localparam logic [2:0] codeMov = 3'b110;
	localparam logic [2:0] codeAlu = 3'b101;
	localparam logic [2:0] codeStr = 3'b100;
	localparam logic [2:0] codeLdr = 3'b011;
	localparam logic [2:0] codeHalt = 3'b111;
	localparam logic [1:0] opAdd = 2'b00;
	localparam logic [1:0] opCmp = 2'b01;
	localparam logic [1:0] opAnd = 2'b10;
	localparam logic [1:0] opMvn = 2'b11;
	localparam logic [1:0] shNone = 2'b00;
	localparam logic [1:0] shLeft = 2'b01;
	localparam logic [1:0] shRightArith = 2'b11;

	// run budget from programs times words times cycles per word with load and readback
	localparam int numRuns = 10;
	localparam int maxProgLen = 64;
	localparam int cyclesPerInstr = 10;
	localparam int apbCycles = 3;
	localparam int cycleLimit = numRuns * maxProgLen * (cyclesPerInstr + 2 * apbCycles);

	logic clk = 1'b0;
	logic reset;
	logic run;
	logic psel;
	logic penable;
	logic pwrite;
	logic [addrWidth-1:0] paddr;
	logic [15:0] pwdata;
	logic [15:0] prdata;
	logic pready;
	logic halted;
	logic [2:0] status;

	integer seed = 32'h6f9f;
	int cycleCount = 0;

	// program being assembled and the words to read back after it
	logic [15:0] prog [$];
	int checkAddrs [$];

	// reference model state
	logic [15:0] regModel [8];
	logic [15:0] memModel [2**addrWidth];
	logic [2:0] flagModel;

	cpuTop #(.addrWidth(addrWidth)) DUT (
		.clk(clk),
		.reset(reset),
		.run(run),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.halted(halted),
		.status(status)
	);

	// 20 ns clock
	always #10 clk = ~clk;

	// global watchdog
	always @(posedge clk) begin
		if (cycleCount >= cycleLimit) begin
			failRun($sformatf("timeout, run passed the limit of %0d cycles", cycleLimit));
		end else begin
			cycleCount <= cycleCount + 1;
		end
	end

	// --------------------------------------------------
	// reporting
	// --------------------------------------------------

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [15:0] actual,
			input logic [15:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, actual, expected));
		end
	endtask

	// --------------------------------------------------
	// reset and apb host
	// --------------------------------------------------

	// reset held high for four rising edges
	task automatic resetDut();
		@(posedge clk);
		reset <= 1'b1;
		run <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic apbWrite(input int addr, input logic [15:0] data);
		@(posedge clk);
		// setup phase
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr[addrWidth-1:0];
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		// pready expected at once in the access phase
		@(negedge clk);
		checkValue("pready", {15'b0, pready}, 16'h0001);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apbRead(input int addr, output logic [15:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr[addrWidth-1:0];
		@(posedge clk);
		penable <= 1'b1;
		// read data valid in the access phase
		@(negedge clk);
		checkValue("pready", {15'b0, pready}, 16'h0001);
		data = prdata;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// host write that the model tracks too
	task automatic preload(input int addr, input logic [15:0] data);
		apbWrite(addr, data);
		memModel[addr] = data;
	endtask

	// --------------------------------------------------
	// reference model and assembler
	// --------------------------------------------------

	function automatic logic [15:0] sext8(input logic [7:0] v);
		return {{8{v[7]}}, v};
	endfunction

	function automatic logic [15:0] sext5(input logic [4:0] v);
		return {{11{v[4]}}, v};
	endfunction

	function automatic logic [15:0] shiftModel(input logic [15:0] v, input logic [1:0] sh);
		case (sh)
			2'b01: return v << 1;
			2'b10: return v >> 1;
			// arithmetic right keeps the sign
			2'b11: return {v[15], v[15:1]};
			default: return v;
		endcase
	endfunction

	// effective address Rn plus sign extended 5 bit offset
	function automatic int memAddr(input int rn, input int off);
		logic [4:0] field;
		logic [15:0] ea;
		field = off[4:0];
		ea = regModel[rn] + sext5(field);
		return int'(ea[addrWidth-1:0]);
	endfunction

	task automatic movImm(input int rn, input logic [7:0] imm);
		prog.push_back({codeMov, opAnd, rn[2:0], imm});
		regModel[rn] = sext8(imm);
	endtask

	task automatic movReg(input int rd, input logic [1:0] sh, input int rm);
		prog.push_back({codeMov, opAdd, 3'b000, rd[2:0], sh, rm[2:0]});
		regModel[rd] = shiftModel(regModel[rm], sh);
	endtask

	task automatic aluInstr(input logic [1:0] op, input int rn, input int rd,
			input logic [1:0] sh, input int rm);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] diff;
		int wide;
		logic ovf;
		a = regModel[rn];
		b = shiftModel(regModel[rm], sh);
		diff = a - b;
		// exact signed difference leaves the 16 bit range on overflow
		wide = $signed(a) - $signed(b);
		ovf = (wide > 32767) || (wide < -32768);
		prog.push_back({codeAlu, op, rn[2:0], rd[2:0], sh, rm[2:0]});
		case (op)
			opAdd: regModel[rd] = a + b;
			// flags N V Z of Rn minus shifted Rm with registers untouched
			opCmp: flagModel = {diff[15], ovf, diff == 16'h0};
			opAnd: regModel[rd] = a & b;
			default: regModel[rd] = ~b;
		endcase
	endtask

	task automatic strInstr(input int rn, input int rd, input int off);
		int addr;
		prog.push_back({codeStr, opAdd, rn[2:0], rd[2:0], off[4:0]});
		addr = memAddr(rn, off);
		memModel[addr] = regModel[rd];
		checkAddrs.push_back(addr);
	endtask

	task automatic ldrInstr(input int rn, input int rd, input int off);
		int addr;
		prog.push_back({codeLdr, opAdd, rn[2:0], rd[2:0], off[4:0]});
		addr = memAddr(rn, off);
		regModel[rd] = memModel[addr];
	endtask

	task automatic haltInstr();
		prog.push_back({codeHalt, 13'h0000});
	endtask

	// wider operand from an imm8 moved left a number of times
	task automatic loadWide(input int rd, input logic [7:0] imm, input int shifts);
		movImm(rd, imm);
		repeat (shifts) movReg(rd, shLeft, rd);
	endtask

	// reset, load over apb, start, wait for halted, read results back
	task automatic runProgram(input string label);
		int i;
		int waited;
		int limit;
		logic [15:0] data;
		resetDut();
		for (i = 0; i < prog.size(); i++) begin
			apbWrite(progBase + i, prog[i]);
			memModel[progBase + i] = prog[i];
		end
		limit = prog.size() * cyclesPerInstr;
		prog.delete();
		@(posedge clk);
		run <= 1'b1;
		@(posedge clk);
		run <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (halted !== 1'b1) begin
			if (waited >= limit) begin
				failRun($sformatf("%s program did not halt within %0d cycles", label, limit));
			end
			waited++;
			@(negedge clk);
		end
		for (i = 0; i < checkAddrs.size(); i++) begin
			apbRead(checkAddrs[i], data);
			checkValue($sformatf("%s mem[%0d]", label, checkAddrs[i]), data,
				memModel[checkAddrs[i]]);
		end
		checkAddrs.delete();
	endtask

	// --------------------------------------------------
	// directed tests
	// --------------------------------------------------

	task automatic resetAndHostPort();
		int addrs [5];
		logic [15:0] data [5];
		logic [15:0] got;
		int i;
		addrs = '{0, 1, 127, 200, 255};
		resetDut();
		@(negedge clk);
		checkValue("halted", {15'b0, halted}, 16'h0000);
		checkValue("status", {13'b0, status}, 16'h0000);
		for (i = 0; i < 5; i++) begin
			data[i] = $random(seed);
			preload(addrs[i], data[i]);
		end
		for (i = 0; i < 5; i++) begin
			apbRead(addrs[i], got);
			checkValue($sformatf("apb mem[%0d]", addrs[i]), got, data[i]);
		end
	endtask

	task automatic movImmStore();
		int i;
		logic [7:0] imm;
		movImm(7, 8'd96);
		// offsets from -6 to +4
		for (i = 0; i < 6; i++) begin
			imm = $random(seed);
			movImm(i, imm);
			strInstr(7, i, 2 * i - 6);
		end
		haltInstr();
		runProgram("mov imm");
	endtask

	task automatic arithAndMoves();
		int sh;
		int off;
		logic [7:0] imm;
		movImm(7, 8'd112);
		imm = $random(seed);
		movImm(1, imm);
		imm = $random(seed);
		loadWide(2, imm, 4);
		imm = $random(seed);
		movImm(3, imm);
		imm = $random(seed);
		loadWide(4, imm, 7);
		off = -16;
		// every shift code on each operation
		for (sh = 0; sh < 4; sh++) begin
			aluInstr(opAdd, 1, 5, sh[1:0], 2);
			strInstr(7, 5, off);
			aluInstr(opAnd, 4, 6, sh[1:0], 3);
			strInstr(7, 6, off + 1);
			aluInstr(opMvn, 0, 5, sh[1:0], 4);
			strInstr(7, 5, off + 2);
			movReg(6, sh[1:0], 2);
			strInstr(7, 6, off + 3);
			off = off + 4;
		end
		haltInstr();
		runProgram("arith");
	endtask

	task automatic compareFlags();
		int k;
		logic [7:0] a;
		logic [7:0] b;
		for (k = 0; k < 5; k++) begin
			a = $random(seed);
			b = $random(seed);
			movImm(7, 8'd96);
			loadWide(1, a, 8);
			if (k < 4) begin
				loadWide(2, b, 7);
				aluInstr(opCmp, 1, 0, k[1:0], 2);
			end else begin
				// equal operands
				movReg(2, shNone, 1);
				aluInstr(opCmp, 1, 0, shNone, 2);
			end
			// Rn and Rm stored to show CMP left them alone
			strInstr(7, 1, 0);
			strInstr(7, 2, 1);
			haltInstr();
			runProgram($sformatf("cmp %0d", k));
			@(negedge clk);
			checkValue("status", {13'b0, status}, {13'b0, flagModel});
		end
	endtask

	task automatic loadAddStore();
		logic [15:0] w1;
		logic [15:0] w2;
		logic [7:0] imm;
		w1 = $random(seed);
		w2 = $random(seed);
		preload(108, w1);
		preload(100, w2);
		checkAddrs.push_back(108);
		checkAddrs.push_back(100);
		movImm(7, 8'd112);
		// negative offsets from base 112
		ldrInstr(7, 1, -4);
		ldrInstr(7, 2, -12);
		imm = $random(seed);
		movImm(3, imm);
		aluInstr(opAdd, 1, 4, shNone, 2);
		aluInstr(opAdd, 4, 5, shRightArith, 3);
		strInstr(7, 4, -1);
		strInstr(7, 5, -2);
		haltInstr();
		runProgram("ldr");
	endtask

	task automatic haltAndRestart();
		logic [7:0] imm;
		logic [15:0] sentinel;
		int guardAddr;
		sentinel = $random(seed);
		preload(97, sentinel);
		checkAddrs.push_back(97);
		movImm(7, 8'd96);
		imm = $random(seed);
		movImm(1, imm);
		strInstr(7, 1, 0);
		haltInstr();
		// word after HALT would overwrite the sentinel if it ran
		guardAddr = progBase + prog.size();
		prog.push_back({codeStr, opAdd, 3'd7, 3'd1, 5'd1});
		checkAddrs.push_back(guardAddr);
		runProgram("halt");
		repeat (20) begin
			@(negedge clk);
			checkValue("halted after HALT", {15'b0, halted}, 16'h0001);
		end
		// held idle without run for longer than the old program needs to halt
		resetDut();
		repeat (40) begin
			@(negedge clk);
			checkValue("halted after reset", {15'b0, halted}, 16'h0000);
		end
		movImm(7, 8'd96);
		imm = $random(seed);
		movImm(2, imm);
		strInstr(7, 2, 2);
		haltInstr();
		runProgram("restart");
	endtask

	// --------------------------------------------------
	// sequence
	// --------------------------------------------------

	initial begin
		reset <= 1'b1;
		run <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= '0;
		pwdata <= '0;
		resetAndHostPort();
		movImmStore();
		arithAndMoves();
		compareFlags();
		loadAddStore();
		haltAndRestart();
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: cpuTop.sv
module cpuTop #(
	parameter int addrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [addrWidth-1:0] paddr,
	input  logic [cpuPkg::dataWidth-1:0] pwdata,
	output logic [cpuPkg::dataWidth-1:0] prdata,
	output logic pready,
	output logic halted,
	output logic [2:0] status
);

	// programs start at word 1, see programCounter

	// strobe bundle from the controller
	datapathCtrlIf ctrlBus ();

	cpuPkg::opcodeT opcode;
	cpuPkg::aluOpT op;
	cpuPkg::shiftT shift;
	logic loadPc;
	logic loadIr;
	logic mSel;
	logic mWrite;
	logic [addrWidth-1:0] pc;
	logic [cpuPkg::regNumWidth-1:0] readNum;
	logic [cpuPkg::regNumWidth-1:0] writeNum;
	logic [cpuPkg::dataWidth-1:0] sximm8;
	logic [cpuPkg::dataWidth-1:0] sximm5;
	logic [cpuPkg::dataWidth-1:0] mData;
	logic [cpuPkg::dataWidth-1:0] cOut;
	logic [cpuPkg::dataWidth-1:0] bOut;

	// --------------------------------------------------
	// control
	// --------------------------------------------------

	controller ctrlFsm (
		.clk(clk),
		.reset(reset),
		.run(run),
		.opcode(opcode),
		.op(op),
		.ctrl(ctrlBus),
		.loadPc(loadPc),
		.loadIr(loadIr),
		.mSel(mSel),
		.mWrite(mWrite),
		.halted(halted)
	);

	programCounter #(.addrWidth(addrWidth)) pcReg (
		.clk(clk),
		.reset(reset),
		.loadPc(loadPc),
		.pc(pc)
	);

	instructionDecoder decoder (
		.clk(clk),
		.reset(reset),
		.loadIr(loadIr),
		.mData(mData),
		.ctrl(ctrlBus),
		.opcode(opcode),
		.op(op),
		.shift(shift),
		.readNum(readNum),
		.writeNum(writeNum),
		.sximm8(sximm8),
		.sximm5(sximm5)
	);

	// --------------------------------------------------
	// data and memory
	// --------------------------------------------------

	datapath #(.addrWidth(addrWidth)) dataPath (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrlBus),
		.op(op),
		.readNum(readNum),
		.writeNum(writeNum),
		.shift(shift),
		.sximm8(sximm8),
		.sximm5(sximm5),
		.mData(mData),
		.pc(pc),
		.cOut(cOut),
		.bOut(bOut),
		.status(status)
	);

	unifiedMemory #(.addrWidth(addrWidth)) ram (
		.clk(clk),
		.mSel(mSel),
		.mWrite(mWrite),
		.pc(pc),
		.cOut(cOut),
		.bOut(bOut),
		.mData(mData),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready)
	);

endmodule

// File: unifiedMemory.sv
module unifiedMemory #(
	parameter int addrWidth = 8
) (
	input  logic clk,
	input  logic mSel,
	input  logic mWrite,
	input  logic [addrWidth-1:0] pc,
	input  logic [cpuPkg::dataWidth-1:0] cOut,
	input  logic [cpuPkg::dataWidth-1:0] bOut,
	output logic [cpuPkg::dataWidth-1:0] mData,
	// apb host port
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [addrWidth-1:0] paddr,
	input  logic [cpuPkg::dataWidth-1:0] pwdata,
	output logic [cpuPkg::dataWidth-1:0] prdata,
	output logic pready
);

	logic [cpuPkg::dataWidth-1:0] mem [2**addrWidth];
	logic [addrWidth-1:0] cpuAddr;
	logic cpuWrite;
	logic hostWrite;
	logic hostSetup;

	// fetch from pc, data access from the low bits of C
	assign cpuAddr = mSel ? cOut[addrWidth-1:0] : pc;
	assign cpuWrite = mSel & mWrite;

	// apb phases
	assign hostSetup = psel & ~penable;
	assign hostWrite = psel & penable & pwrite;

	// no wait states
	assign pready = psel & penable;

	always_ff @(posedge clk) begin
		// host write lands at the end of the access phase
		if (hostWrite) begin
			mem[paddr] <= pwdata;
		end
		// processor write is last, so it wins on a shared address
		if (cpuWrite) begin
			mem[cpuAddr] <= bOut;
		end
		// processor port reads every cycle
		mData <= mem[cpuAddr];
		// host read captured at setup, valid in the access phase
		if (hostSetup) begin
			prdata <= mem[paddr];
		end
	end

endmodule

// File: datapath.sv
module datapath #(
	parameter int addrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	datapathCtrlIf.datapath ctrl,
	input  cpuPkg::aluOpT op,
	input  logic [cpuPkg::regNumWidth-1:0] readNum,
	input  logic [cpuPkg::regNumWidth-1:0] writeNum,
	input  cpuPkg::shiftT shift,
	input  logic [cpuPkg::dataWidth-1:0] sximm8,
	input  logic [cpuPkg::dataWidth-1:0] sximm5,
	input  logic [cpuPkg::dataWidth-1:0] mData,
	input  logic [addrWidth-1:0] pc,
	output logic [cpuPkg::dataWidth-1:0] cOut,
	output logic [cpuPkg::dataWidth-1:0] bOut,
	output logic [2:0] status
);

	localparam int dw = cpuPkg::dataWidth;

	logic [dw-1:0] writeData;
	logic [dw-1:0] readData;
	logic [dw-1:0] aReg;
	logic [dw-1:0] bReg;
	logic [dw-1:0] cReg;
	logic [dw-1:0] shifted;
	logic [dw-1:0] aIn;
	logic [dw-1:0] bIn;
	logic [dw-1:0] aluOut;
	logic overflow;

	// --------------------------------------------------
	// writeback and registers
	// --------------------------------------------------

	always_comb begin
		case (ctrl.vsel)
			cpuPkg::MDATA: writeData = mData;
			cpuPkg::SXIMM8: writeData = sximm8;
			// pc zero extended to a full word
			cpuPkg::PCVAL: writeData = {{(dw - addrWidth){1'b0}}, pc};
			default: writeData = cReg;
		endcase
	end

	registerFile regFile (
		.clk(clk),
		.write(ctrl.write),
		.writeNum(writeNum),
		.readNum(readNum),
		.writeData(writeData),
		.readData(readData)
	);

	// operand and result registers
	always_ff @(posedge clk) begin
		if (ctrl.loadA) begin
			aReg <= readData;
		end
		if (ctrl.loadB) begin
			bReg <= readData;
		end
		if (ctrl.loadC) begin
			cReg <= aluOut;
		end
	end

	// --------------------------------------------------
	// shifter and alu
	// --------------------------------------------------

	always_comb begin
		case (shift)
			cpuPkg::shLeft: shifted = {bReg[dw-2:0], 1'b0};
			cpuPkg::shRightLogic: shifted = {1'b0, bReg[dw-1:1]};
			// sign bit copied in
			cpuPkg::shRightArith: shifted = {bReg[dw-1], bReg[dw-1:1]};
			default: shifted = bReg;
		endcase
	end

	// aSel zeroes A for moves, bSel takes the memory offset
	assign aIn = ctrl.aSel ? '0 : aReg;
	assign bIn = ctrl.bSel ? sximm5 : shifted;

	always_comb begin
		case (op)
			cpuPkg::ADD: aluOut = aIn + bIn;
			cpuPkg::CMP: aluOut = aIn - bIn;
			cpuPkg::AND: aluOut = aIn & bIn;
			default: aluOut = ~bIn;
		endcase
	end

	// signed overflow of A minus B
	assign overflow = (aIn[dw-1] != bIn[dw-1]) && (aluOut[dw-1] != aIn[dw-1]);

	// status is N V Z, only loaded by CMP
	always_ff @(posedge clk) begin
		if (reset) begin
			status <= '0;
		end else if (ctrl.loadS) begin
			status <= {aluOut[dw-1], overflow, aluOut == '0};
		end
	end

	assign cOut = cReg;
	assign bOut = bReg;

endmodule

// File: registerFile.sv
module registerFile (
	input  logic clk,
	input  logic write,
	input  logic [cpuPkg::regNumWidth-1:0] writeNum,
	input  logic [cpuPkg::regNumWidth-1:0] readNum,
	input  logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readData
);

	// R0 to R7
	logic [cpuPkg::dataWidth-1:0] regs [2**cpuPkg::regNumWidth];

	// write at the edge where write is high
	always_ff @(posedge clk) begin
		if (write) begin
			regs[writeNum] <= writeData;
		end
	end

	// read is combinational
	assign readData = regs[readNum];

endmodule

// File: instructionDecoder.sv
module instructionDecoder (
	input  logic clk,
	input  logic reset,
	input  logic loadIr,
	input  logic [cpuPkg::dataWidth-1:0] mData,
	datapathCtrlIf.decoder ctrl,
	output cpuPkg::opcodeT opcode,
	output cpuPkg::aluOpT op,
	output cpuPkg::shiftT shift,
	output logic [cpuPkg::regNumWidth-1:0] readNum,
	output logic [cpuPkg::regNumWidth-1:0] writeNum,
	output logic [cpuPkg::dataWidth-1:0] sximm8,
	output logic [cpuPkg::dataWidth-1:0] sximm5
);

	logic [cpuPkg::dataWidth-1:0] ir;
	logic [cpuPkg::regNumWidth-1:0] regNum;

	// instruction register
	always_ff @(posedge clk) begin
		if (reset) begin
			ir <= '0;
		end else if (loadIr) begin
			ir <= mData;
		end
	end

	// fixed fields
	assign opcode = cpuPkg::opcodeT'(ir[cpuPkg::opcodeLsb +: $bits(cpuPkg::opcodeT)]);
	assign op = cpuPkg::aluOpT'(ir[cpuPkg::opLsb +: $bits(cpuPkg::aluOpT)]);
	assign shift = cpuPkg::shiftT'(ir[cpuPkg::shiftLsb +: $bits(cpuPkg::shiftT)]);

	// register number picked by nsel
	always_comb begin
		case (ctrl.nsel)
			cpuPkg::RN: regNum = ir[cpuPkg::rnLsb +: cpuPkg::regNumWidth];
			cpuPkg::RD: regNum = ir[cpuPkg::rdLsb +: cpuPkg::regNumWidth];
			default: regNum = ir[cpuPkg::rmLsb +: cpuPkg::regNumWidth];
		endcase
	end

	// read and write always address the same register
	assign readNum = regNum;
	assign writeNum = regNum;

	// sign extended immediates
	assign sximm8 = {
		{(cpuPkg::dataWidth - cpuPkg::imm8Width){ir[cpuPkg::imm8Width-1]}},
		ir[cpuPkg::imm8Width-1:0]
	};
	assign sximm5 = {
		{(cpuPkg::dataWidth - cpuPkg::imm5Width){ir[cpuPkg::imm5Width-1]}},
		ir[cpuPkg::imm5Width-1:0]
	};

endmodule

// File: programCounter.sv
module programCounter #(
	parameter int addrWidth = 8
) (
	input  logic clk,
	input  logic reset,
	input  logic loadPc,
	output logic [addrWidth-1:0] pc
);

	// pc steps during loadPc, before the fetch read of loadRam,
	// so the first instruction of a program sits at word 1
	// and pc points at the instruction in ir during execute
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
		end else if (loadPc) begin
			// wraps at the top of memory
			pc <= pc + 1'b1;
		end
	end

endmodule

// File: controller.sv
module controller (
	input  logic clk,
	input  logic reset,
	input  logic run,
	input  cpuPkg::opcodeT opcode,
	input  cpuPkg::aluOpT op,
	datapathCtrlIf.controller ctrl,
	output logic loadPc,
	output logic loadIr,
	output logic mSel,
	output logic mWrite,
	output logic halted
);

	// command word, registered together with the state
	// each field holds its value until a later state changes it
	typedef struct packed {
		cpuPkg::regSelT nsel;
		cpuPkg::writeSelT vsel;
		logic loadA;
		logic loadB;
		logic write;
		logic aSel;
		logic bSel;
		logic loadC;
		logic loadS;
		logic loadPc;
		logic mSel;
		logic mWrite;
		logic loadIr;
		logic halted;
	} cmdT;

	cpuPkg::ctrlState state;
	cpuPkg::ctrlState stateNext;
	cmdT cmd;
	cmdT cmdNext;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cpuPkg::initiatePc;
			cmd <= '0;
		end else begin
			state <= stateNext;
			cmd <= cmdNext;
		end
	end

	// --------------------------------------------------
	// next state and strobes of the next state
	// --------------------------------------------------

	always_comb begin
		stateNext = state;
		cmdNext = cmd;
		case (state)
			cpuPkg::initiatePc: begin
				stateNext = cpuPkg::idle;
				cmdNext = '0;
			end
			// hold here until the host lets the program run
			cpuPkg::idle: begin
				if (run) begin
					stateNext = cpuPkg::loadPc;
					cmdNext.loadPc = 1'b1;
				end
			end
			cpuPkg::loadPc: begin
				stateNext = cpuPkg::loadRam;
				cmdNext.loadPc = 1'b0;
			end
			// ram word at pc is on mData during loadIr
			cpuPkg::loadRam: begin
				stateNext = cpuPkg::loadIr;
				cmdNext.loadIr = 1'b1;
			end
			// ir is valid from instrFirst on, so that state only decodes
			cpuPkg::loadIr: begin
				stateNext = cpuPkg::instrFirst;
				cmdNext.loadIr = 1'b0;
			end
			cpuPkg::instrFirst: begin
				case (opcode)
					cpuPkg::MOV: begin
						if (op == cpuPkg::AND) begin
							// immediate move, written straight into Rn
							stateNext = cpuPkg::instrLast;
							cmdNext.nsel = cpuPkg::RN;
							cmdNext.vsel = cpuPkg::SXIMM8;
							cmdNext.write = 1'b1;
						end else begin
							stateNext = cpuPkg::putInB;
							cmdNext.nsel = cpuPkg::RM;
							cmdNext.loadB = 1'b1;
						end
					end
					cpuPkg::ALU: begin
						stateNext = cpuPkg::putInB;
						cmdNext.nsel = cpuPkg::RM;
						cmdNext.loadB = 1'b1;
					end
					cpuPkg::LDR, cpuPkg::STR: begin
						stateNext = cpuPkg::putInA;
						cmdNext.nsel = cpuPkg::RN;
						cmdNext.loadA = 1'b1;
					end
					// HALT, and any opcode not defined, stops the machine
					default: begin
						stateNext = cpuPkg::halt;
						cmdNext.halted = 1'b1;
					end
				endcase
			end
			cpuPkg::putInB: begin
				cmdNext.loadB = 1'b0;
				if (opcode == cpuPkg::STR) begin
					// address in C, Rd in B
					stateNext = cpuPkg::instrLast;
					cmdNext.mSel = 1'b1;
					cmdNext.mWrite = 1'b1;
				end else if (opcode == cpuPkg::MOV || op == cpuPkg::MVN) begin
					// single operand, A forced to zero
					stateNext = cpuPkg::aluOpToC;
					cmdNext.aSel = 1'b1;
					cmdNext.bSel = 1'b0;
					cmdNext.loadC = 1'b1;
				end else begin
					stateNext = cpuPkg::readRn;
					cmdNext.nsel = cpuPkg::RN;
				end
			end
			cpuPkg::readRn: begin
				stateNext = cpuPkg::putInA;
				cmdNext.loadA = 1'b1;
			end
			cpuPkg::putInA: begin
				cmdNext.loadA = 1'b0;
				cmdNext.aSel = 1'b0;
				if (opcode == cpuPkg::ALU && op == cpuPkg::CMP) begin
					// compare only updates status
					stateNext = cpuPkg::instrLast;
					cmdNext.bSel = 1'b0;
					cmdNext.loadS = 1'b1;
				end else begin
					stateNext = cpuPkg::aluOpToC;
					// memory ops add sximm5 to Rn for the address
					cmdNext.bSel = (opcode == cpuPkg::LDR || opcode == cpuPkg::STR);
					cmdNext.loadC = 1'b1;
				end
			end
			cpuPkg::aluOpToC: begin
				cmdNext.loadC = 1'b0;
				cmdNext.nsel = cpuPkg::RD;
				if (opcode == cpuPkg::LDR || opcode == cpuPkg::STR) begin
					stateNext = cpuPkg::readRd;
					// LDR puts C on the ram address here
					cmdNext.mSel = (opcode == cpuPkg::LDR);
				end else begin
					stateNext = cpuPkg::instrLast;
					cmdNext.vsel = cpuPkg::CVAL;
					cmdNext.write = 1'b1;
				end
			end
			cpuPkg::readRd: begin
				if (opcode == cpuPkg::LDR) begin
					// loaded word arrives on mData in instrLast
					stateNext = cpuPkg::instrLast;
					cmdNext.vsel = cpuPkg::MDATA;
					cmdNext.write = 1'b1;
				end else begin
					stateNext = cpuPkg::putInB;
					cmdNext.loadB = 1'b1;
				end
			end
			// clear everything and fetch the next instruction
			cpuPkg::instrLast: begin
				stateNext = cpuPkg::loadPc;
				cmdNext = '0;
				cmdNext.loadPc = 1'b1;
			end
			// stays halted until reset
			cpuPkg::halt: begin
				stateNext = cpuPkg::halt;
			end
			default: begin
				stateNext = cpuPkg::initiatePc;
				cmdNext = '0;
			end
		endcase
	end

	// --------------------------------------------------
	// outputs straight from the command word
	// --------------------------------------------------

	assign ctrl.nsel = cmd.nsel;
	assign ctrl.vsel = cmd.vsel;
	assign ctrl.loadA = cmd.loadA;
	assign ctrl.loadB = cmd.loadB;
	assign ctrl.write = cmd.write;
	assign ctrl.aSel = cmd.aSel;
	assign ctrl.bSel = cmd.bSel;
	assign ctrl.loadC = cmd.loadC;
	assign ctrl.loadS = cmd.loadS;
	assign loadPc = cmd.loadPc;
	assign loadIr = cmd.loadIr;
	assign mSel = cmd.mSel;
	assign mWrite = cmd.mWrite;
	assign halted = cmd.halted;

endmodule

// File: datapathCtrlIf.sv
interface datapathCtrlIf;

	// register select and writeback select
	cpuPkg::regSelT nsel;
	cpuPkg::writeSelT vsel;

	// load strobes and operand selects
	logic loadA;
	logic loadB;
	logic write;
	logic aSel;
	logic bSel;
	logic loadC;
	logic loadS;

	// the controller owns every strobe
	modport controller (
		output nsel, vsel, loadA, loadB, write, aSel, bSel, loadC, loadS
	);

	modport datapath (
		input vsel, loadA, loadB, write, aSel, bSel, loadC, loadS
	);

	// decoder only needs to know which field names the register
	modport decoder (
		input nsel
	);

endinterface

// File: cpuPkg.sv
package cpuPkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------

	// one word size for registers, instructions and memory
	localparam int dataWidth = 16;
	// eight registers, R0 to R7
	localparam int regNumWidth = 3;
	localparam int imm8Width = 8;
	localparam int imm5Width = 5;

	// --------------------------------------------------
	// instruction fields
	// --------------------------------------------------

	// opcode[15:13] op[12:11] Rn[10:8] Rd[7:5] shift[4:3] Rm[2:0]
	localparam int opcodeLsb = 13;
	localparam int opLsb = 11;
	localparam int rnLsb = 8;
	localparam int rdLsb = 5;
	localparam int shiftLsb = 3;
	localparam int rmLsb = 0;

	// --------------------------------------------------
	// encodings
	// --------------------------------------------------

	// controller states, fetch first and then execute
	typedef enum logic [3:0] {
		initiatePc = 4'b0000,
		idle       = 4'b0001,
		loadPc     = 4'b0010,
		loadRam    = 4'b0011,
		loadIr     = 4'b0100,
		instrFirst = 4'b0101,
		putInB     = 4'b0110,
		readRn     = 4'b0111,
		putInA     = 4'b1000,
		aluOpToC   = 4'b1001,
		readRd     = 4'b1010,
		instrLast  = 4'b1011,
		halt       = 4'b1100
	} ctrlState;

	typedef enum logic [2:0] {
		MOV  = 3'b110,
		ALU  = 3'b101,
		STR  = 3'b100,
		LDR  = 3'b011,
		HALT = 3'b111
	} opcodeT;

	// with MOV, ADD is the register form and AND the immediate form
	typedef enum logic [1:0] {
		ADD = 2'b00,
		CMP = 2'b01,
		AND = 2'b10,
		MVN = 2'b11
	} aluOpT;

	// instruction field that names the register
	typedef enum logic [1:0] {
		RN = 2'b00,
		RD = 2'b01,
		RM = 2'b10
	} regSelT;

	// register file writeback source
	typedef enum logic [1:0] {
		MDATA  = 2'b00,
		SXIMM8 = 2'b01,
		PCVAL  = 2'b10,
		CVAL   = 2'b11
	} writeSelT;

	typedef enum logic [1:0] {
		shNone       = 2'b00,
		shLeft       = 2'b01,
		shRightLogic = 2'b10,
		shRightArith = 2'b11
	} shiftT;

endpackage
